// File: src/elevator_pkg.sv
/*
 * Elevator floor request controller, shared definitions
 * Floor count, floor number width, button mask type and the
 * request queue sizing used across the whole controller
 */

package elevator_pkg;

    //////////////////////////////
    // Floors
    //////////////////////////////

    // Floors served, numbered 0 to NUM_FLOORS-1
    localparam int NUM_FLOORS = 11;

    // Bits needed to hold a floor number
    localparam int FLOOR_W = 4;

    // A single floor number
    typedef logic [FLOOR_W-1:0] floor_t;

    // One bit per floor, used for buttons and lamps
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    //////////////////////////////
    // Request queue
    //////////////////////////////

    // Each floor is pending at most once, so 16 entries always suffice
    localparam int QUEUE_DEPTH = 16;

    // Read and write pointer width
    localparam int QUEUE_PTR_W = 4;

endpackage

// File: src/request_latch.sv
/*
 * Request latch
 * Samples call and panel buttons, keeps the button lamps and
 * reports at most one newly accepted floor per cycle. The lowest
 * eligible floor wins, and a held button is taken on a later cycle.
 * Lamps of the current floor are cleared on arrival.
 */

`timescale 1ns/1ns

module request_latch
    import elevator_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        arrived,
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        emergency_btn,
    input  logic        power_switch,
    input  floor_t      current_floor,
    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights,
    output logic        new_request,
    output floor_t      new_floor
);

    // Requests are only taken with power on and no emergency
    logic        enabled;
    floor_mask_t here_mask;
    floor_mask_t eligible;
    floor_mask_t pick_mask;
    floor_mask_t clear_mask;
    floor_t      pick_floor;
    logic        found;

    assign enabled = power_switch && !emergency_btn;

    //////////////////////////////
    // Candidate floors
    //////////////////////////////

    // One-hot of the floor the car is standing at
    always_comb begin
        for (int i = 0; i < NUM_FLOORS; i++) begin
            here_mask[i] = (current_floor == FLOOR_W'(i));
        end
    end

    // Pressed on either set, not lit on either set, not the current floor
    assign eligible = (floor_call_buttons | panel_buttons)
                    & ~(call_button_lights | panel_button_lights)
                    & ~here_mask;

    // Lowest eligible floor wins
    always_comb begin
        found      = 1'b0;
        pick_floor = '0;
        pick_mask  = '0;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (eligible[i] && !found) begin
                found        = 1'b1;
                pick_floor   = FLOOR_W'(i);
                pick_mask[i] = 1'b1;
            end
        end
    end

    // One floor per cycle, pushed on the same edge the lamp lights
    assign new_request = enabled && found;
    assign new_floor   = pick_floor;

    //////////////////////////////
    // Lamp registers
    //////////////////////////////

    // Both lamps of the current floor go dark on arrival
    assign clear_mask = arrived ? here_mask : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            // Clear wins over a set of the same floor
            if (new_request) begin
                call_button_lights  <= (call_button_lights
                                       | (pick_mask & floor_call_buttons))
                                       & ~clear_mask;
                panel_button_lights <= (panel_button_lights
                                       | (pick_mask & panel_buttons))
                                       & ~clear_mask;
            end else begin
                call_button_lights  <= call_button_lights & ~clear_mask;
                panel_button_lights <= panel_button_lights & ~clear_mask;
            end
        end
    end

endmodule

// File: src/request_queue.sv
/*
 * Request queue
 * Circular buffer of pending floors in arrival order. The head is
 * the target floor. Push and pop may share an edge, and the queue
 * never fills since every floor is pending at most once.
 */

`timescale 1ns/1ns

module request_queue
    import elevator_pkg::*;
(
    input  logic   clock,
    input  logic   reset_n,
    input  logic   push,
    input  logic   pop,
    input  floor_t push_floor,
    output floor_t target_floor,
    output logic   request_pending
);

    // Entry storage, no reset on payload
    floor_t mem [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W-1:0] wr_ptr;

    // Occupancy, one extra bit so a full queue is representable
    logic [QUEUE_PTR_W:0]   count;

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_floor;
        end
    end

    //////////////////////////////
    // Pointers and count
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own at the power of two depth
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////
    // Head of queue
    //////////////////////////////

    assign request_pending = (count != '0);

    // Shows floor zero while nothing is queued
    assign target_floor = request_pending ? mem[rd_ptr] : '0;

endmodule

// File: src/dispatch.sv
/*
 * Dispatch
 * Drives the target floor, travel direction and activate level to
 * the motion machine, flags arrival at the target and grants door
 * requests while the car stands still with power on
 */

`timescale 1ns/1ns

module dispatch
    import elevator_pkg::*;
(
    input  logic   clock,
    input  logic   reset_n,
    input  floor_t target_floor,
    input  logic   request_pending,
    input  floor_t current_floor,
    input  logic   elevator_moving,
    input  logic   emergency_btn,
    input  logic   power_switch,
    input  logic   door_open_btn,
    input  logic   door_close_btn,
    output floor_t elevator_floor_selector,
    output logic   activate_elevator,
    output logic   direction_selector,
    output logic   door_open_allowed,
    output logic   door_close_allowed,
    output logic   arrived
);

    logic idle;
    logic serve;
    logic travel;

    // Car still with power on
    assign idle = power_switch && !elevator_moving;

    // A pending request can be acted on
    assign serve = idle && !emergency_btn && request_pending;

    // Standing at the target, consumed by latch and queue on the next edge
    assign arrived = serve && (target_floor == current_floor);
    assign travel  = serve && (target_floor != current_floor);

    // Selector is the head of the queue
    assign elevator_floor_selector = target_floor;

    //////////////////////////////
    // Motion request
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            activate_elevator  <= 1'b0;
            direction_selector <= 1'b0;
        end else if (arrived) begin
            activate_elevator <= 1'b0;
        end else if (travel) begin
            activate_elevator  <= 1'b1;
            // High is up
            direction_selector <= (target_floor > current_floor);
        end else if (elevator_moving) begin
            // Keep the current run going
            activate_elevator  <= activate_elevator;
            direction_selector <= direction_selector;
        end else begin
            activate_elevator <= 1'b0;
        end
    end

    //////////////////////////////
    // Door grants
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else if (idle) begin
            door_open_allowed  <= door_open_btn;
            door_close_allowed <= door_close_btn;
        end else begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end
    end

endmodule

// File: src/floor_logic_control_unit.sv
/*
 * Floor logic control unit
 * Top level of the elevator floor request controller. Connects the
 * request latch, the request queue and the dispatch block between
 * the car buttons and the motion state machine.
 */

`timescale 1ns/1ns

module floor_logic_control_unit
    import elevator_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,

    // Buttons
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  logic        emergency_btn,
    input  logic        power_switch,

    // Status from the motion machine
    input  floor_t      current_floor,
    input  logic        elevator_moving,

    // Commands to the motion machine
    output floor_t      elevator_floor_selector,
    output logic        direction_selector,
    output logic        activate_elevator,
    output logic        door_open_allowed,
    output logic        door_close_allowed,

    // Lamps
    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights
);

    logic   new_request;
    floor_t new_floor;
    floor_t target_floor;
    logic   request_pending;
    logic   arrived;

    //////////////////////////////
    // Input side
    //////////////////////////////

    request_latch request_latch_inst (
        .clock               (clock),
        .reset_n             (reset_n),
        .arrived             (arrived),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .new_request         (new_request),
        .new_floor           (new_floor)
    );

    //////////////////////////////
    // Pending floors
    //////////////////////////////

    request_queue request_queue_inst (
        .clock           (clock),
        .reset_n         (reset_n),
        .push            (new_request),
        .pop             (arrived),
        .push_floor      (new_floor),
        .target_floor    (target_floor),
        .request_pending (request_pending)
    );

    //////////////////////////////
    // Output side
    //////////////////////////////

    dispatch dispatch_inst (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .target_floor            (target_floor),
        .request_pending         (request_pending),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .elevator_floor_selector (elevator_floor_selector),
        .activate_elevator       (activate_elevator),
        .direction_selector      (direction_selector),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed),
        .arrived                 (arrived)
    );

endmodule

// File: tests/floor_logic_props.sv
/*
 * Request queue properties
 * Bound to the request queue, checks occupancy bounds, pops on an
 * empty queue and unknown floors on push
 */

`timescale 1ns/1ns

module floor_logic_props
    import elevator_pkg::*;
(
    input logic                 clock,
    input logic                 reset_n,
    input logic                 push,
    input logic                 pop,
    input floor_t               push_floor,
    input logic [QUEUE_PTR_W:0] count
);

    // Occupancy stays within the buffer
    assert property (@(posedge clock) disable iff (!reset_n) count <= QUEUE_DEPTH)
        else $error("queue count above depth");

    // Arrival never pops an empty queue
    assert property (@(posedge clock) disable iff (!reset_n) !(pop && count == '0))
        else $error("pop while queue empty");

    // Pushed floors and the reset line are always known
    assert property (@(posedge clock) !$isunknown(reset_n) && !(push && $isunknown(push_floor)))
        else $error("unknown floor or reset on push");

endmodule

bind request_queue floor_logic_props floor_logic_props_inst (
    .clock      (clock),
    .reset_n    (reset_n),
    .push       (push),
    .pop        (pop),
    .push_floor (push_floor),
    .count      (count)
);

// File: tests/floor_logic_checker.sv
/*
 * Checker for the floor logic control unit
 * Compares the DUT outputs with the expected values of each table
 * row, prints one line per test and keeps the counts
 */

`timescale 1ns/1ns

module floor_logic_checker
    import elevator_pkg::*;
(
    input floor_mask_t call_button_lights,
    input floor_mask_t panel_button_lights,
    input floor_t      elevator_floor_selector,
    input logic        activate_elevator,
    input logic        direction_selector,
    input logic        door_open_allowed,
    input logic        door_close_allowed
);

    int passes = 0;
    int errors = 0;

    // Outputs packed as lamps, selector, activate, direction, doors
    task automatic check_row(
        input string       name,
        input floor_mask_t exp_call,
        input floor_mask_t exp_panel,
        input floor_t      exp_sel,
        input logic        exp_act,
        input logic        exp_dir,
        input logic        exp_open,
        input logic        exp_close
    );
        logic [29:0] expected;
        logic [29:0] actual;
        expected = {exp_call, exp_panel, exp_sel, exp_act, exp_dir, exp_open, exp_close};
        actual   = {call_button_lights, panel_button_lights, elevator_floor_selector,
                    activate_elevator, direction_selector,
                    door_open_allowed, door_close_allowed};
        if (actual === expected) begin
            passes++;
            $display("Ok   %s value %h", name, actual);
        end else begin
            errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Closing line with the counts
    task automatic report_counts();
        $display("Tests run %0d, passed %0d, failed %0d", passes + errors, passes, errors);
    endtask

endmodule

// File: tests/floor_logic_tb.sv
/*
 * Testbench for the floor logic control unit
 * Applies a table of button and motion inputs, lets the checker
 * compare the outputs and guards the run with a watchdog
 */

`timescale 1ns/1ns

module floor_logic_tb
    import elevator_pkg::*;
;

    localparam int PERIOD = 4;
    localparam int RESET_CYCLES = 5;

    typedef struct {
        string       name;
        floor_mask_t call;
        floor_mask_t panel;
        logic        door_open;
        logic        door_close;
        logic        emergency;
        logic        power;
        floor_t      floor_now;
        logic        moving;
        int          hold;
        floor_mask_t exp_call;
        floor_mask_t exp_panel;
        floor_t      exp_sel;
        logic        exp_act;
        logic        exp_dir;
        logic        exp_open;
        logic        exp_close;
    } row_t;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    logic        elevator_moving;
    floor_t      elevator_floor_selector;
    logic        direction_selector;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;

    row_t rows [$];

    floor_logic_control_unit floor_logic_control_unit_inst (.*);

    floor_logic_checker checker_inst (
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .elevator_floor_selector (elevator_floor_selector),
        .activate_elevator       (activate_elevator),
        .direction_selector      (direction_selector),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    always #(PERIOD / 2) clock = ~clock;

    task automatic add_row(input string name, input int call, input int panel,
                           input logic dopen, input logic dclose, input logic emerg,
                           input logic power, input int flr, input logic moving,
                           input int hold, input int ecall, input int epanel,
                           input int esel, input logic eact, input logic edir,
                           input logic eopen, input logic eclose);
        row_t r;
        r = '{name, floor_mask_t'(call), floor_mask_t'(panel), dopen, dclose, emerg,
              power, floor_t'(flr), moving, hold, floor_mask_t'(ecall),
              floor_mask_t'(epanel), floor_t'(esel), eact, edir, eopen, eclose};
        rows.push_back(r);
    endtask

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    initial begin
        //       name             call   panel  do dc em pw fl mv h  ecall  epanel sel a d o c
        add_row("reset_state",     'h000, 'h000, 0, 0, 0, 1, 0, 0, 1, 'h000, 'h000, 0, 0, 0, 0, 0);
        add_row("lowest_first",    'h004, 'h020, 0, 0, 0, 1, 0, 0, 1, 'h004, 'h000, 2, 0, 0, 0, 0);
        add_row("held_panel_5",    'h004, 'h020, 0, 0, 0, 1, 0, 0, 1, 'h004, 'h020, 2, 1, 1, 0, 0);
        add_row("press_current",   'h000, 'h001, 0, 0, 0, 1, 0, 0, 1, 'h004, 'h020, 2, 1, 1, 0, 0);
        add_row("direction_down",  'h000, 'h000, 0, 0, 0, 1, 7, 0, 1, 'h004, 'h020, 2, 1, 0, 0, 0);
        add_row("arrive_floor_2",  'h000, 'h000, 0, 0, 0, 1, 2, 0, 1, 'h000, 'h020, 5, 0, 0, 0, 0);
        add_row("emergency_press", 'h100, 'h000, 0, 0, 1, 1, 2, 0, 2, 'h000, 'h020, 5, 0, 1, 0, 0);
        add_row("power_off_press", 'h100, 'h000, 1, 0, 0, 0, 2, 0, 2, 'h000, 'h020, 5, 0, 1, 0, 0);
        add_row("door_idle",       'h000, 'h000, 1, 1, 0, 1, 2, 0, 1, 'h000, 'h020, 5, 1, 1, 1, 1);
        add_row("door_moving",     'h000, 'h000, 1, 1, 0, 1, 2, 1, 1, 'h000, 'h020, 5, 1, 1, 0, 0);
        add_row("arrive_floor_5",  'h000, 'h000, 0, 0, 0, 1, 5, 0, 2, 'h000, 'h000, 0, 0, 1, 0, 0);
    end

    //////////////////////////////
    // Reset and apply loop
    //////////////////////////////

    initial begin
        clock              = 1'b0;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        current_floor      = '0;
        elevator_moving    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset_n <= 1'b1;
        foreach (rows[i]) begin
            @(posedge clock);
            floor_call_buttons <= rows[i].call;
            panel_buttons      <= rows[i].panel;
            door_open_btn      <= rows[i].door_open;
            door_close_btn     <= rows[i].door_close;
            emergency_btn      <= rows[i].emergency;
            power_switch       <= rows[i].power;
            current_floor      <= rows[i].floor_now;
            elevator_moving    <= rows[i].moving;
            for (int c = 0; c < rows[i].hold; c++) begin
                @(posedge clock);
                // Floor buttons are seen on one edge only
                floor_call_buttons <= '0;
                panel_buttons      <= '0;
            end
            @(negedge clock);
            checker_inst.check_row(rows[i].name, rows[i].exp_call, rows[i].exp_panel,
                                   rows[i].exp_sel, rows[i].exp_act, rows[i].exp_dir,
                                   rows[i].exp_open, rows[i].exp_close);
        end
        checker_inst.report_counts();
        if (checker_inst.errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Twice the length of reset plus every row with its apply cycle
    initial begin
        int cycles;
        #1;
        cycles = RESET_CYCLES;
        foreach (rows[i]) begin
            cycles += rows[i].hold + 1;
        end
        #(cycles * PERIOD * 2);
        $display("Run timed out before all table rows were checked");
        $display("test failed");
        $finish;
    end

endmodule

// File: tb.f
src/elevator_pkg.sv
src/request_latch.sv
src/request_queue.sv
src/dispatch.sv
src/floor_logic_control_unit.sv
tests/floor_logic_props.sv
tests/floor_logic_checker.sv
tests/floor_logic_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the floor logic testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module floor_logic_tb \
    -f tb.f \
    -o floor_logic_sim

./obj_dir/floor_logic_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    exit 0
else
    exit 1
fi
